/* include/daq_defines.svh */
`ifndef DAQ_DEFINES_SVH
`define DAQ_DEFINES_SVH

// Readout structure
`define DAQ_N_CH            4
`define DAQ_FIFO_DEPTH      8

// Bus and word widths
`define DAQ_ABUS_W          16
`define DAQ_DBUS_W          8
`define DAQ_PAYLOAD_W       28
`define DAQ_ID_W            4
`define DAQ_OVF_W           8

// Identifier of channel 0, later channels count up from here
`define DAQ_ID_BASE         4

// Readback constants
`define DAQ_VERSION         1
`define DAQ_VERSION_MINOR   2
`define DAQ_VERSION_MAJOR   0
`define DAQ_BOARD_ID        0

// System register map
`define DAQ_REG_VERSION     0
`define DAQ_REG_MINOR       1
`define DAQ_REG_MAJOR       2
`define DAQ_REG_BOARD       3
`define DAQ_REG_CONFIGURED  4
`define DAQ_REG_EN_MASK     6
`define DAQ_REG_OVF_BASE    16

`endif

/* rtl/daq_pkg.sv */
`include "daq_defines.svh"

package daq_pkg;

    // Local bus
    typedef logic [`DAQ_ABUS_W-1:0]    bus_addr_t;
    typedef logic [`DAQ_DBUS_W-1:0]    bus_data_t;

    // Hit word as delivered by the decoder
    typedef logic [`DAQ_PAYLOAD_W-1:0] payload_t;

    // Source identifier, top nibble of every output word
    typedef logic [`DAQ_ID_W-1:0]      data_id_t;

    // Saturating drop count
    typedef logic [`DAQ_OVF_W-1:0]     ovf_count_t;

    // One bit per receive channel
    typedef logic [`DAQ_N_CH-1:0]      ch_mask_t;

    typedef struct packed {
        data_id_t data_id;
        payload_t payload;
    } fifo_word_t;

    typedef struct packed {
        logic       empty;
        ovf_count_t ovf_count;
    } ch_status_t;

endpackage

/* rtl/daq_sys_regs.sv */
`include "daq_defines.svh"

module daq_sys_regs (
    input  logic                BUS_CLK,
    input  logic                BUS_RST,
    input  daq_pkg::bus_addr_t  i_bus_add,
    input  daq_pkg::bus_data_t  i_bus_data,
    input  logic                i_bus_rd,
    input  logic                i_bus_wr,
    input  daq_pkg::ch_status_t i_ch_status [`DAQ_N_CH],
    output daq_pkg::bus_data_t  o_bus_data,
    output daq_pkg::ch_mask_t   o_ch_enable,
    output daq_pkg::ch_mask_t   o_ovf_clear
);

    logic               configured;
    daq_pkg::ch_mask_t  ch_enable;
    daq_pkg::ch_mask_t  ovf_hit;
    daq_pkg::bus_data_t rd_data;

    // Overflow counter block decode, one hit bit per channel
    always_comb begin
        ovf_hit = '0;
        for (int n = 0; n < `DAQ_N_CH; n++) begin
            if (i_bus_add == daq_pkg::bus_addr_t'(`DAQ_REG_OVF_BASE + n)) begin
                ovf_hit[n] = 1'b1;
            end
        end
    end

    // Writable registers
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            configured <= 1'b0;
            ch_enable  <= '0;
        end else if (i_bus_wr) begin
            case (i_bus_add)
                `DAQ_REG_CONFIGURED: configured <= i_bus_data[0];
                `DAQ_REG_EN_MASK:    ch_enable  <= i_bus_data[`DAQ_N_CH-1:0];
                default: ;
            endcase
        end
    end

    // Any write to a counter address gives a one-cycle clear, data ignored
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            o_ovf_clear <= '0;
        end else if (i_bus_wr) begin
            o_ovf_clear <= ovf_hit;
        end else begin
            o_ovf_clear <= '0;
        end
    end

    // Read mux
    always_comb begin
        rd_data = '0;
        case (i_bus_add)
            `DAQ_REG_VERSION:    rd_data = daq_pkg::bus_data_t'(`DAQ_VERSION);
            `DAQ_REG_MINOR:      rd_data = daq_pkg::bus_data_t'(`DAQ_VERSION_MINOR);
            `DAQ_REG_MAJOR:      rd_data = daq_pkg::bus_data_t'(`DAQ_VERSION_MAJOR);
            `DAQ_REG_BOARD:      rd_data = daq_pkg::bus_data_t'(`DAQ_BOARD_ID);
            `DAQ_REG_CONFIGURED: rd_data = daq_pkg::bus_data_t'(configured);
            `DAQ_REG_EN_MASK:    rd_data = daq_pkg::bus_data_t'(ch_enable);
            default: begin
                // Unmapped addresses fall through as zero
                for (int n = 0; n < `DAQ_N_CH; n++) begin
                    if (ovf_hit[n]) begin
                        rd_data = daq_pkg::bus_data_t'(i_ch_status[n].ovf_count);
                    end
                end
            end
        endcase
    end

    // Read data registered, held until the next read
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            o_bus_data <= '0;
        end else if (i_bus_rd) begin
            o_bus_data <= rd_data;
        end
    end

    assign o_ch_enable = ch_enable;

endmodule

/* rtl/rx_channel.sv */
`include "daq_defines.svh"

module rx_channel #(
    parameter int CH_INDEX = 0
) (
    input  logic                BUS_CLK,
    input  logic                BUS_RST,
    input  logic                i_enable,
    input  logic                i_ovf_clear,
    input  logic                i_rx_valid,
    input  daq_pkg::payload_t   i_rx_data,
    input  logic                i_grant,
    output daq_pkg::ch_status_t o_status,
    output daq_pkg::fifo_word_t o_head
);

    localparam int DEPTH = `DAQ_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam daq_pkg::data_id_t CH_ID = daq_pkg::data_id_t'(`DAQ_ID_BASE + CH_INDEX);

    daq_pkg::fifo_word_t mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      level;
    daq_pkg::ovf_count_t ovf_count;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;
    logic                drop;

    assign empty = (level == '0);
    assign full  = (level == (PTR_W + 1)'(DEPTH));

    // Disabled channel ignores its strobe entirely, nothing is counted
    assign push = i_rx_valid & i_enable & ~full;
    assign drop = i_rx_valid & i_enable & full;
    assign pop  = i_grant & ~empty;

    // Tag with the channel identifier on the way in
    always_ff @(posedge BUS_CLK) begin
        if (push) begin
            mem[wr_ptr] <= '{data_id: CH_ID, payload: i_rx_data};
        end
    end

    // Pointers and fill level
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;
            endcase
        end
    end

    // Dropped words, saturating; clear wins over a drop in the same cycle
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ovf_count <= '0;
        end else if (i_ovf_clear) begin
            ovf_count <= '0;
        end else if (drop && (ovf_count != '1)) begin
            ovf_count <= ovf_count + 1'b1;
        end
    end

    // Head word is visible without a read cycle
    assign o_head   = mem[rd_ptr];
    assign o_status = '{empty: empty, ovf_count: ovf_count};

endmodule

/* rtl/rr_arbiter.sv */
`include "daq_defines.svh"

module rr_arbiter (
    input  logic                BUS_CLK,
    input  logic                BUS_RST,
    input  daq_pkg::ch_status_t i_ch_status [`DAQ_N_CH],
    input  daq_pkg::fifo_word_t i_heads [`DAQ_N_CH],
    input  logic                i_arb_ready,
    output daq_pkg::ch_mask_t   o_grant,
    output logic                o_arb_write,
    output daq_pkg::fifo_word_t o_arb_data
);

    localparam int N     = `DAQ_N_CH;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] sel;
    logic [IDX_W-1:0] sel_next;
    logic             found;
    logic             take;

    // First non-empty channel at or after the pointer
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int off = 0; off < N; off++) begin
            idx = (int'(rr_ptr) + off) % N;
            if (!found && !i_ch_status[idx].empty) begin
                found = 1'b1;
                sel   = IDX_W'(idx);
            end
        end
    end

    assign take     = i_arb_ready & found;
    assign sel_next = (sel == IDX_W'(N - 1)) ? '0 : sel + 1'b1;

    // One-hot pop, same edge as the output register load
    always_comb begin
        o_grant = '0;
        if (take) begin
            o_grant[sel] = 1'b1;
        end
    end

    // Write strobe follows a ready cycle by one clock
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rr_ptr      <= '0;
            o_arb_write <= 1'b0;
        end else begin
            o_arb_write <= take;
            if (take) begin
                rr_ptr <= sel_next;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (take) begin
            o_arb_data <= i_heads[sel];
        end
    end

endmodule

/* rtl/daq_core_top.sv */
`include "daq_defines.svh"

module daq_core_top (
    input  logic                BUS_CLK,
    input  logic                BUS_RST,

    // Local bus
    input  daq_pkg::bus_addr_t  i_bus_add,
    input  daq_pkg::bus_data_t  i_bus_data,
    input  logic                i_bus_rd,
    input  logic                i_bus_wr,
    output daq_pkg::bus_data_t  o_bus_data,

    // Decoded hit words, one strobe per channel
    input  daq_pkg::ch_mask_t   i_rx_valid,
    input  daq_pkg::payload_t   i_rx_data [`DAQ_N_CH],

    // Output FIFO
    input  logic                i_arb_ready,
    output logic                o_arb_write,
    output daq_pkg::fifo_word_t o_arb_data
);

    daq_pkg::ch_mask_t   ch_enable;
    daq_pkg::ch_mask_t   ovf_clear;
    daq_pkg::ch_mask_t   grant;
    daq_pkg::ch_status_t ch_status [`DAQ_N_CH];
    daq_pkg::fifo_word_t ch_head [`DAQ_N_CH];

    daq_sys_regs u_sys_regs (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_bus_add   (i_bus_add),
        .i_bus_data  (i_bus_data),
        .i_bus_rd    (i_bus_rd),
        .i_bus_wr    (i_bus_wr),
        .i_ch_status (ch_status),
        .o_bus_data  (o_bus_data),
        .o_ch_enable (ch_enable),
        .o_ovf_clear (ovf_clear)
    );

    // Fast readout channels, identifiers count up from the base
    for (genvar n = 0; n < `DAQ_N_CH; n++) begin : g_rx
        rx_channel #(
            .CH_INDEX (n)
        ) u_rx (
            .BUS_CLK     (BUS_CLK),
            .BUS_RST     (BUS_RST),
            .i_enable    (ch_enable[n]),
            .i_ovf_clear (ovf_clear[n]),
            .i_rx_valid  (i_rx_valid[n]),
            .i_rx_data   (i_rx_data[n]),
            .i_grant     (grant[n]),
            .o_status    (ch_status[n]),
            .o_head      (ch_head[n])
        );
    end

    rr_arbiter u_arbiter (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_ch_status (ch_status),
        .i_heads     (ch_head),
        .i_arb_ready (i_arb_ready),
        .o_grant     (grant),
        .o_arb_write (o_arb_write),
        .o_arb_data  (o_arb_data)
    );

endmodule

/* dv/daq_core_sva.sv */
`include "daq_defines.svh"

module daq_core_sva (
    input logic                BUS_CLK,
    input logic                BUS_RST,
    input logic                i_arb_ready,
    input daq_pkg::ch_mask_t   o_grant,
    input logic                o_arb_write,
    input daq_pkg::fifo_word_t o_arb_data
);

    // Failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // Write strobe must follow a ready cycle
    a_write_after_ready: assert property (
        @(posedge BUS_CLK) disable iff (BUS_RST)
        o_arb_write |-> $past(i_arb_ready)
    ) else begin
        fail_count++;
        $error("o_arb_write high without i_arb_ready in the previous cycle");
    end

    // Only channel identifiers leave the arbiter
    a_id_range: assert property (
        @(posedge BUS_CLK) disable iff (BUS_RST)
        o_arb_write |-> ((o_arb_data.data_id >= `DAQ_ID_BASE) &&
                         (o_arb_data.data_id <= `DAQ_ID_BASE + `DAQ_N_CH - 1))
    ) else begin
        fail_count++;
        $error("Output word identifier %0d out of range", o_arb_data.data_id);
    end

    a_grant_onehot: assert property (
        @(posedge BUS_CLK) disable iff (BUS_RST)
        $onehot0(o_grant)
    ) else begin
        fail_count++;
        $error("More than one grant bit set: %b", o_grant);
    end

endmodule

bind rr_arbiter daq_core_sva u_sva (
    .BUS_CLK     (BUS_CLK),
    .BUS_RST     (BUS_RST),
    .i_arb_ready (i_arb_ready),
    .o_grant     (o_grant),
    .o_arb_write (o_arb_write),
    .o_arb_data  (o_arb_data)
);

/* dv/tb_daq_core.sv */
`include "daq_defines.svh"

module tb_daq_core;

    // Phase lengths in cycles, the watchdog budget derives from them
    localparam int T_REGS    = 60;
    localparam int T_DIS     = 80;
    localparam int T_TRAFFIC = 1600;
    localparam int T_OVF     = 420;
    localparam int T_CLEAR   = 60;
    localparam int T_TOTAL   = T_REGS + T_DIS + T_TRAFFIC + T_OVF + T_CLEAR;
    localparam int DEPTH     = `DAQ_FIFO_DEPTH;

    logic                BUS_CLK = 1'b0;
    logic                BUS_RST;
    daq_pkg::bus_addr_t  i_bus_add;
    daq_pkg::bus_data_t  i_bus_data;
    logic                i_bus_rd;
    logic                i_bus_wr;
    daq_pkg::bus_data_t  o_bus_data;
    daq_pkg::ch_mask_t   i_rx_valid;
    daq_pkg::payload_t   i_rx_data [`DAQ_N_CH];
    logic                i_arb_ready;
    logic                o_arb_write;
    daq_pkg::fifo_word_t o_arb_data;

    // Reference model state
    daq_pkg::fifo_word_t exp_q [`DAQ_N_CH][$];
    daq_pkg::ch_mask_t   model_en;
    int                  words_seen [`DAQ_N_CH];
    int                  errors = 0;

    daq_core_top UUT (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_bus_add   (i_bus_add),
        .i_bus_data  (i_bus_data),
        .i_bus_rd    (i_bus_rd),
        .i_bus_wr    (i_bus_wr),
        .o_bus_data  (o_bus_data),
        .i_rx_valid  (i_rx_valid),
        .i_rx_data   (i_rx_data),
        .i_arb_ready (i_arb_ready),
        .o_arb_write (o_arb_write),
        .o_arb_data  (o_arb_data)
    );

    always #50 BUS_CLK = ~BUS_CLK;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic write_reg(input daq_pkg::bus_addr_t addr, input daq_pkg::bus_data_t data);
        @(posedge BUS_CLK);
        i_bus_add  <= addr;
        i_bus_data <= data;
        i_bus_wr   <= 1'b1;
        @(posedge BUS_CLK);
        i_bus_wr   <= 1'b0;
    endtask

    // Read data is registered, so it is sampled half a cycle after the load edge
    task automatic read_reg(input daq_pkg::bus_addr_t addr, output daq_pkg::bus_data_t data);
        @(posedge BUS_CLK);
        i_bus_add <= addr;
        i_bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        i_bus_rd  <= 1'b0;
        @(negedge BUS_CLK);
        data = o_bus_data;
    endtask

    task automatic check_reg(input string name, input int addr, input int exp);
        daq_pkg::bus_data_t data;
        read_reg(daq_pkg::bus_addr_t'(addr), data);
        check_value(name, exp, data);
    endtask

    // Enabled channel keeps a word while its FIFO has room
    task automatic accept_word(input int ch, input daq_pkg::payload_t data);
        daq_pkg::fifo_word_t word;
        word.data_id = daq_pkg::data_id_t'(`DAQ_ID_BASE + ch);
        word.payload = data;
        if (model_en[ch] && (exp_q[ch].size() < DEPTH)) begin
            exp_q[ch].push_back(word);
        end
    endtask

    task automatic drive_traffic(input int cycles, input int strobe_pct, input int ready_pct);
        daq_pkg::payload_t data;
        logic              valid;
        for (int c = 0; c < cycles; c++) begin
            @(posedge BUS_CLK);
            for (int n = 0; n < `DAQ_N_CH; n++) begin
                valid = ($urandom % 100) < strobe_pct;
                data  = daq_pkg::payload_t'($urandom);
                i_rx_valid[n] <= valid;
                i_rx_data[n]  <= data;
                if (valid) begin
                    accept_word(n, data);
                end
            end
            i_arb_ready <= ($urandom % 100) < ready_pct;
        end
        @(posedge BUS_CLK);
        i_rx_valid <= '0;
    endtask

    task automatic send_burst(input int ch, input int count);
        daq_pkg::payload_t data;
        for (int i = 0; i < count; i++) begin
            @(posedge BUS_CLK);
            data = daq_pkg::payload_t'($urandom);
            i_rx_valid[ch] <= 1'b1;
            i_rx_data[ch]  <= data;
            accept_word(ch, data);
        end
        @(posedge BUS_CLK);
        i_rx_valid <= '0;
    endtask

    // Waits until the monitor has seen every queued word
    task automatic wait_drain(input int limit);
        int pending;
        int cycles;
        cycles = 0;
        do begin
            @(negedge BUS_CLK);
            pending = 0;
            for (int n = 0; n < `DAQ_N_CH; n++) begin
                pending += exp_q[n].size();
            end
            cycles++;
        end while ((pending != 0) && (cycles < limit));
        if (pending != 0) begin
            errors++;
            $display("Output FIFO stream stalled with %0d words still expected", pending);
        end
    endtask

    // Output monitor, stable at the falling edge
    always @(negedge BUS_CLK) begin : monitor
        int                  ch;
        daq_pkg::fifo_word_t exp;
        if (!BUS_RST && o_arb_write) begin
            ch = int'(o_arb_data.data_id) - `DAQ_ID_BASE;
            if ((ch < 0) || (ch >= `DAQ_N_CH)) begin
                errors++;
                $display("Output word carries unknown identifier %0d", o_arb_data.data_id);
            end else begin
                // Every word that leaves is counted, expected or not
                words_seen[ch]++;
                if (exp_q[ch].size() == 0) begin
                    errors++;
                    $display("Channel %0d produced a word that was never accepted", ch);
                end else begin
                    exp = exp_q[ch].pop_front();
                    check_value("output word", exp, o_arb_data);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (T_TOTAL * 4) @(posedge BUS_CLK);
        $display("Watchdog expired before the tests completed");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int                 c1;
        int                 c2;
        int                 n1;
        int                 n2;
        int                 seen1;
        int                 seen2;
        int                 sva_fails;
        daq_pkg::bus_data_t wdata;
        void'($urandom(32'h4504));
        BUS_RST     <= 1'b1;
        i_bus_add   <= '0;
        i_bus_data  <= '0;
        i_bus_rd    <= 1'b0;
        i_bus_wr    <= 1'b0;
        i_rx_valid  <= '0;
        i_arb_ready <= 1'b0;
        for (int n = 0; n < `DAQ_N_CH; n++) begin
            i_rx_data[n] <= '0;
            words_seen[n] = 0;
        end
        model_en = '0;
        repeat (5) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;

        // Register reset values and readback
        check_reg("version", `DAQ_REG_VERSION, `DAQ_VERSION);
        check_reg("minor", `DAQ_REG_MINOR, `DAQ_VERSION_MINOR);
        check_reg("major", `DAQ_REG_MAJOR, `DAQ_VERSION_MAJOR);
        check_reg("board", `DAQ_REG_BOARD, `DAQ_BOARD_ID);
        check_reg("enable reset", `DAQ_REG_EN_MASK, 0);
        check_reg("configured reset", `DAQ_REG_CONFIGURED, 0);
        wdata = daq_pkg::bus_data_t'($urandom);
        write_reg(`DAQ_REG_EN_MASK, wdata);
        check_reg("enable readback", `DAQ_REG_EN_MASK, wdata & 8'h0f);
        write_reg(`DAQ_REG_CONFIGURED, 8'h01);
        check_reg("configured readback", `DAQ_REG_CONFIGURED, 1);
        check_reg("unused address", 5, 0);
        write_reg(`DAQ_REG_EN_MASK, 8'h00);

        // Disabled channels, enough strobes to overflow if they were counted
        drive_traffic(12, 100, 0);
        drive_traffic(20, 50, 100);
        wait_drain(T_DIS);
        for (int n = 0; n < `DAQ_N_CH; n++) begin
            check_value("disabled words", 0, words_seen[n]);
            check_reg("disabled overflow", `DAQ_REG_OVF_BASE + n, 0);
        end

        // Tagging and per-channel order with random ready
        write_reg(`DAQ_REG_EN_MASK, 8'h0f);
        model_en = '1;
        drive_traffic(T_TRAFFIC - 200, 12, 85);
        i_arb_ready <= 1'b1;
        wait_drain(200);
        for (int n = 0; n < `DAQ_N_CH; n++) begin
            check_value("queue empty", 0, exp_q[n].size());
            check_reg("traffic overflow", `DAQ_REG_OVF_BASE + n, 0);
        end

        // Overflow with ready held low, second channel saturates
        c1 = $urandom % `DAQ_N_CH;
        c2 = (c1 + 1 + ($urandom % (`DAQ_N_CH - 1))) % `DAQ_N_CH;
        n1 = DEPTH + 1 + ($urandom % 16);
        n2 = DEPTH + 262;
        @(posedge BUS_CLK);
        i_arb_ready <= 1'b0;
        send_burst(c1, n1);
        send_burst(c2, n2);
        check_reg("overflow count", `DAQ_REG_OVF_BASE + c1, n1 - DEPTH);
        check_reg("overflow saturation", `DAQ_REG_OVF_BASE + c2, 255);
        seen1 = words_seen[c1];
        seen2 = words_seen[c2];
        @(posedge BUS_CLK);
        i_arb_ready <= 1'b1;
        wait_drain(60);
        check_value("drained words", DEPTH, words_seen[c1] - seen1);
        check_value("drained words", DEPTH, words_seen[c2] - seen2);

        // Clearing one counter leaves the others alone
        write_reg(daq_pkg::bus_addr_t'(`DAQ_REG_OVF_BASE + c1), daq_pkg::bus_data_t'($urandom));
        for (int n = 0; n < `DAQ_N_CH; n++) begin
            check_reg("counter clear", `DAQ_REG_OVF_BASE + n, (n == c2) ? 255 : 0);
        end

        repeat (4) @(posedge BUS_CLK);
        sva_fails = UUT.u_arbiter.u_sva.fail_count;
        $display("Check errors: %0d, assertion failures: %0d", errors, sva_fails);
        if ((errors == 0) && (sva_fails == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
rtl/daq_pkg.sv
rtl/daq_sys_regs.sv
rtl/rx_channel.sv
rtl/rr_arbiter.sv
rtl/daq_core_top.sv
dv/daq_core_sva.sv
dv/tb_daq_core.sv

/* Bender.yml */
package:
  name: daq_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/daq_pkg.sv
      - rtl/daq_sys_regs.sv
      - rtl/rx_channel.sv
      - rtl/rr_arbiter.sv
      - rtl/daq_core_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/daq_core_sva.sv
      - dv/tb_daq_core.sv
